// ==== tests/frame_fetch_stimulus.txt ====
# columns: op reg data, all in hex
# op 0 writes data to register reg, op 1 sets the pixel count of the next frame, op 2 starts a frame
# registers: 0 base, 1 words per line, 2 pitch, 3 line count
# four lines of eight words
0 0 01000
0 1 8
0 2 40
0 3 4
1 0 20
2 0 0
# new geometry with one word per line
0 0 2f000
0 1 1
0 2 10
0 3 3
1 0 3
2 0 0
# two long lines, enough to fill the reader FIFOs
0 0 80abc
0 1 14
0 2 100
0 3 2
1 0 28
2 0 0

// ==== flist.f ====
design/axi_pkg.sv
design/fb_pkg.sv
design/burst_req_if.sv
design/addr_iter.sv
design/sync_fifo.sv
design/axi_burst_reader.sv
design/fetch_regs.sv
design/line_fetch_ctrl.sv
design/frame_fetch_top.sv
tests/frame_fetch_checker.sv
tests/tb_frame_fetch.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the frame fetch testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module tb_frame_fetch -o sim_frame_fetch
./obj_dir/sim_frame_fetch > sim.log
cat sim.log

if grep -q "Done: errors found" sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

// ==== tests/tb_frame_fetch.sv ====
`timescale 1ns/1ps

module tb_frame_fetch import axi_pkg::*, fb_pkg::*; ();

  localparam int ADDR_WIDTH = axi_addr_width_def;
  localparam int DATA_WIDTH = axi_data_width_def;

  // DUT inputs start out at known values
  logic                      axi_clk     = 1'b0;
  logic                      axi_resetn  = 1'b0;
  logic                      reg_wr_en   = 1'b0;
  logic [reg_addr_width-1:0] reg_wr_addr = '0;
  logic [ADDR_WIDTH-1:0]     reg_wr_data = '0;
  logic                      pix_ready   = 1'b0;
  logic                      sub_arready = 1'b0;
  logic [DATA_WIDTH-1:0]     sub_rdata   = '0;
  logic [1:0]                sub_rresp   = 2'b00;
  logic                      sub_rvalid  = 1'b0;

  logic [DATA_WIDTH-1:0] pix_data;
  logic                  pix_valid;
  logic                  pix_line_last;
  logic                  frame_done;
  logic [ADDR_WIDTH-1:0] sub_araddr;
  logic                  sub_arvalid;
  logic                  sub_rready;

  integer seed = 32'hcdb9e40c;

  // stimulus file contents, one entry per command line
  int   cmd_op[$];
  int   cmd_sel[$];
  int   cmd_data[$];
  int   exp_pixels     = 0;
  int   total_words    = 0;
  int   timeout_cycles = 0;
  int   stim_errors    = 0;
  int   error_total;
  logic stim_loaded    = 1'b0;

  // read responses waiting in the memory model and the cycle each may go out
  logic [DATA_WIDTH-1:0] resp_data[$];
  int                    resp_due[$];
  int                    cycle = 0;

  always #2 axi_clk = ~axi_clk;

  frame_fetch_top i_frame_fetch_top (
    .axi_clk       (axi_clk),
    .axi_resetn    (axi_resetn),
    .reg_wr_en     (reg_wr_en),
    .reg_wr_addr   (reg_wr_addr),
    .reg_wr_data   (reg_wr_data),
    .pix_data      (pix_data),
    .pix_valid     (pix_valid),
    .pix_line_last (pix_line_last),
    .pix_ready     (pix_ready),
    .frame_done    (frame_done),
    .sub_araddr    (sub_araddr),
    .sub_arvalid   (sub_arvalid),
    .sub_arready   (sub_arready),
    .sub_rdata     (sub_rdata),
    .sub_rresp     (sub_rresp),
    .sub_rvalid    (sub_rvalid),
    .sub_rready    (sub_rready)
  );

  frame_fetch_checker #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH),
    .STRIDE     (axi_stride_def)
  ) i_frame_fetch_checker (
    .axi_clk       (axi_clk),
    .axi_resetn    (axi_resetn),
    .reg_wr_en     (reg_wr_en),
    .reg_wr_addr   (reg_wr_addr),
    .reg_wr_data   (reg_wr_data),
    .pix_data      (pix_data),
    .pix_valid     (pix_valid),
    .pix_line_last (pix_line_last),
    .pix_ready     (pix_ready),
    .frame_done    (frame_done),
    .exp_pixels    (exp_pixels),
    .error_total   (error_total)
  );

  function automatic int random_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // memory model, every word is its own address folded with a fixed pattern
  always @(posedge axi_clk) begin
    if (!axi_resetn) begin
      sub_arready <= 1'b0;
      sub_rvalid  <= 1'b0;
      pix_ready   <= 1'b0;
      resp_data.delete();
      resp_due.delete();
    end else begin
      cycle = cycle + 1;
      if (sub_arvalid && sub_arready) begin
        resp_data.push_back(sub_araddr[15:0] ^ 16'h5a5a);
        resp_due.push_back(cycle + random_below(4));
      end
      // responses leave in order, each one only once its delay has run out
      if (!sub_rvalid || sub_rready) begin
        if (resp_data.size() > 0 && resp_due[0] <= cycle) begin
          sub_rdata  <= resp_data.pop_front();
          sub_rvalid <= 1'b1;
          void'(resp_due.pop_front());
        end else begin
          sub_rvalid <= 1'b0;
        end
      end
      sub_arready <= (random_below(2) != 0);
      // the pixel sink stalls about one cycle in four
      pix_ready   <= (random_below(4) != 0);
    end
  end

  task automatic write_reg(input logic [reg_addr_width-1:0] sel,
                           input logic [ADDR_WIDTH-1:0] data);
    @(posedge axi_clk);
    reg_wr_en   <= 1'b1;
    reg_wr_addr <= sel;
    reg_wr_data <= data;
    @(posedge axi_clk);
    reg_wr_en   <= 1'b0;
  endtask

  // frame_done is a registered pulse, so sampling it on the edge is safe
  task automatic run_frame();
    write_reg(REG_START, '0);
    @(posedge axi_clk);
    while (!frame_done) begin
      @(posedge axi_clk);
    end
  endtask

  initial begin
    int    fd;
    int    n;
    int    op;
    int    sel;
    int    data;
    string line;
    fd = $fopen("tests/frame_fetch_stimulus.txt", "r");
    if (fd == 0) begin
      $display("the stimulus file tests/frame_fetch_stimulus.txt could not be opened");
      $display("Done: errors found");
      $finish;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() == 0 || line[0] == "#") begin
          continue;
        end
        n = $sscanf(line, "%h %h %h", op, sel, data);
        if (n == 3) begin
          cmd_op.push_back(op);
          cmd_sel.push_back(sel);
          cmd_data.push_back(data);
          if (op == 1) begin
            total_words += data;
          end
        end
      end
      $fclose(fd);
      timeout_cycles = total_words * 40 + 1000;
      stim_loaded    = 1'b1;

      repeat (2) @(posedge axi_clk);
      axi_resetn <= 1'b1;

      foreach (cmd_op[i]) begin
        case (cmd_op[i])
          0: write_reg(reg_addr_width'(cmd_sel[i]), ADDR_WIDTH'(cmd_data[i]));
          1: exp_pixels <= cmd_data[i];
          2: run_frame();
          default: begin
            stim_errors++;
            $display("stimulus entry %0d has the unknown command %0d", i, cmd_op[i]);
          end
        endcase
      end

      // idle tail so a stray pixel or frame_done still gets seen
      repeat (20) @(posedge axi_clk);
      i_frame_fetch_checker.print_counts(stim_errors);
      if (error_total + stim_errors == 0) begin
        $display("Done: no errors");
      end else begin
        $display("Done: errors found");
      end
      $finish;
    end
  end

  // watchdog, its budget grows with the number of words in the file
  initial begin
    wait (stim_loaded);
    repeat (timeout_cycles) @(posedge axi_clk);
    $display("timeout: the frames did not finish within %0d cycles", timeout_cycles);
    i_frame_fetch_checker.print_counts(stim_errors);
    $display("Done: errors found");
    $finish;
  end

endmodule

// ==== tests/frame_fetch_checker.sv ====
`timescale 1ns/1ps

module frame_fetch_checker import fb_pkg::*; #(
  parameter int ADDR_WIDTH = 20,
  parameter int DATA_WIDTH = 16,
  parameter int STRIDE     = 2
) (
  input  logic                      axi_clk,
  input  logic                      axi_resetn,
  input  logic                      reg_wr_en,
  input  logic [reg_addr_width-1:0] reg_wr_addr,
  input  logic [ADDR_WIDTH-1:0]     reg_wr_data,
  input  logic [DATA_WIDTH-1:0]     pix_data,
  input  logic                      pix_valid,
  input  logic                      pix_line_last,
  input  logic                      pix_ready,
  input  logic                      frame_done,
  input  int                        exp_pixels,
  output int                        error_total
);

  // geometry as last written on the register ports
  int geo_base;
  int geo_words;
  int geo_pitch;
  int geo_count;

  // geometry of the frame in flight, frozen when its start is written
  int cur_base;
  int cur_words;
  int cur_pitch;
  int cur_count;

  // position of the next expected pixel inside the frame
  int line_idx;
  int word_idx;
  int frame_pixels;
  int frames_seen;
  logic armed;

  int data_errors;
  int last_errors;
  int frame_errors;

  logic [31:0]           exp_addr;
  logic [DATA_WIDTH-1:0] exp_data;
  logic                  exp_last;

  assign error_total = data_errors + last_errors + frame_errors;

  initial begin
    data_errors  = 0;
    last_errors  = 0;
    frame_errors = 0;
    frames_seen  = 0;
  end

  // everything is sampled on the rising edge, before the DUT registers move
  always @(posedge axi_clk) begin
    if (!axi_resetn) begin
      armed     = 1'b0;
      geo_base  = 0;
      geo_words = 0;
      geo_pitch = 0;
      geo_count = 0;
    end else begin
      if (reg_wr_en) begin
        case (reg_wr_addr)
          REG_BASE:       geo_base  = int'(reg_wr_data);
          REG_LINE_WORDS: geo_words = int'(reg_wr_data);
          REG_PITCH:      geo_pitch = int'(reg_wr_data);
          REG_LINE_COUNT: geo_count = int'(reg_wr_data);
          REG_START: begin
            // the registers settle before the start pulse, so the shadow copy is valid here
            armed        = 1'b1;
            cur_base     = geo_base;
            cur_words    = geo_words;
            cur_pitch    = geo_pitch;
            cur_count    = geo_count;
            line_idx     = 0;
            word_idx     = 0;
            frame_pixels = 0;
          end
          default: begin
          end
        endcase
      end

      if (pix_valid && pix_ready) begin
        if (!armed) begin
          frame_errors++;
          $display("at %0t ns a pixel was handed out while no frame was running", $time);
        end else begin
          // word k of line l sits at base + l * pitch + stride * k
          exp_addr = 32'(cur_base + line_idx * cur_pitch + STRIDE * word_idx);
          exp_data = exp_addr[15:0] ^ 16'h5a5a;
          exp_last = (word_idx == cur_words - 1);
          if (pix_data !== exp_data) begin
            data_errors++;
            $display("FAILED at %0t ns: pix_data expected %h actual %h",
                     $time, exp_data, pix_data);
          end
          if (pix_line_last !== exp_last) begin
            last_errors++;
            $display("FAILED at %0t ns: pix_line_last expected %b actual %b",
                     $time, exp_last, pix_line_last);
          end
          frame_pixels++;
          // the prediction walks on by its own count, so one bad flag does not shift the rest
          if (exp_last) begin
            line_idx++;
            word_idx = 0;
          end else begin
            word_idx++;
          end
        end
      end

      if (frame_done) begin
        if (!armed) begin
          frame_errors++;
          $display("at %0t ns frame_done pulsed without a frame having been started", $time);
        end else begin
          if (frame_pixels != exp_pixels) begin
            frame_errors++;
            $display("FAILED at %0t ns: pixel count expected %0d actual %0d",
                     $time, exp_pixels, frame_pixels);
          end
          if (line_idx != cur_count) begin
            frame_errors++;
            $display("FAILED at %0t ns: line count expected %0d actual %0d",
                     $time, cur_count, line_idx);
          end
          armed = 1'b0;
          frames_seen++;
        end
      end
    end
  end

  // closing summary, the stimulus count comes from the playback side
  task automatic print_counts(input int stim_errors);
    $display("frames %0d, data errors %0d, line last errors %0d, frame errors %0d, stimulus errors %0d",
             frames_seen, data_errors, last_errors, frame_errors, stim_errors);
  endtask

endmodule

// ==== design/frame_fetch_top.sv ====
`timescale 1ns/1ps

module frame_fetch_top import axi_pkg::*, fb_pkg::*; #(
  parameter int ADDR_WIDTH = axi_addr_width_def,
  parameter int DATA_WIDTH = axi_data_width_def,
  parameter int LEN_WIDTH  = axi_len_width_def,
  parameter int STRIDE     = axi_stride_def
) (
  input  logic                      axi_clk,
  input  logic                      axi_resetn,
  input  logic                      reg_wr_en,
  input  logic [reg_addr_width-1:0] reg_wr_addr,
  input  logic [ADDR_WIDTH-1:0]     reg_wr_data,
  output logic [DATA_WIDTH-1:0]     pix_data,
  output logic                      pix_valid,
  output logic                      pix_line_last,
  input  logic                      pix_ready,
  output logic                      frame_done,
  output logic [ADDR_WIDTH-1:0]     sub_araddr,
  output logic                      sub_arvalid,
  input  logic                      sub_arready,
  input  logic [DATA_WIDTH-1:0]     sub_rdata,
  input  logic [1:0]                sub_rresp,
  input  logic                      sub_rvalid,
  output logic                      sub_rready
);

  // frame geometry from the register block
  logic [ADDR_WIDTH-1:0] base_addr;
  logic [LEN_WIDTH:0]    line_words;
  logic [ADDR_WIDTH-1:0] line_pitch;
  logic [ADDR_WIDTH-1:0] line_count;
  logic                  start;

  burst_req_if #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH),
    .LEN_WIDTH  (LEN_WIDTH)
  ) i_burst_req_if ();

  fetch_regs #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .LEN_WIDTH  (LEN_WIDTH)
  ) i_fetch_regs (
    .axi_clk     (axi_clk),
    .axi_resetn  (axi_resetn),
    .reg_wr_en   (reg_wr_en),
    .reg_wr_addr (reg_addr_e'(reg_wr_addr)),
    .reg_wr_data (reg_wr_data),
    .base_addr   (base_addr),
    .line_words  (line_words),
    .line_pitch  (line_pitch),
    .line_count  (line_count),
    .start       (start)
  );

  line_fetch_ctrl #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH),
    .LEN_WIDTH  (LEN_WIDTH)
  ) i_line_fetch_ctrl (
    .axi_clk       (axi_clk),
    .axi_resetn    (axi_resetn),
    .base_addr     (base_addr),
    .line_words    (line_words),
    .line_pitch    (line_pitch),
    .line_count    (line_count),
    .start         (start),
    .req           (i_burst_req_if.ctrl),
    .pix_data      (pix_data),
    .pix_valid     (pix_valid),
    .pix_line_last (pix_line_last),
    .pix_ready     (pix_ready),
    .frame_done    (frame_done)
  );

  axi_burst_reader #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH),
    .LEN_WIDTH  (LEN_WIDTH),
    .STRIDE     (STRIDE)
  ) i_axi_burst_reader (
    .axi_clk     (axi_clk),
    .axi_resetn  (axi_resetn),
    .req         (i_burst_req_if.reader),
    .sub_araddr  (sub_araddr),
    .sub_arvalid (sub_arvalid),
    .sub_arready (sub_arready),
    .sub_rdata   (sub_rdata),
    .sub_rresp   (axi_resp_e'(sub_rresp)),
    .sub_rvalid  (sub_rvalid),
    .sub_rready  (sub_rready)
  );

endmodule

// ==== design/line_fetch_ctrl.sv ====
`timescale 1ns/1ps

module line_fetch_ctrl import fb_pkg::*; #(
  parameter int ADDR_WIDTH = 20,
  parameter int DATA_WIDTH = 16,
  parameter int LEN_WIDTH  = 8
) (
  input  logic                  axi_clk,
  input  logic                  axi_resetn,
  input  logic [ADDR_WIDTH-1:0] base_addr,
  input  logic [LEN_WIDTH:0]    line_words,
  input  logic [ADDR_WIDTH-1:0] line_pitch,
  input  logic [ADDR_WIDTH-1:0] line_count,
  input  logic                  start,
  burst_req_if.ctrl             req,
  output logic [DATA_WIDTH-1:0] pix_data,
  output logic                  pix_valid,
  output logic                  pix_line_last,
  input  logic                  pix_ready,
  output logic                  frame_done
);

  fetch_state_e state;

  // start address of the current line and the number of lines already done
  logic [ADDR_WIDTH-1:0] line_addr;
  logic [ADDR_WIDTH-1:0] line_idx;
  logic                  last_line;
  logic                  line_done;

  assign line_done = req.rvalid && req.rready && req.rlast;
  assign last_line = (line_idx == line_count - 1'b1);

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      state     <= F_IDLE;
      line_addr <= '0;
      line_idx  <= '0;
    end else begin
      case (state)
        F_IDLE: begin
          // a start that comes in the middle of a frame is ignored
          if (start) begin
            line_addr <= base_addr;
            line_idx  <= '0;
            if (line_count == '0) begin
              state <= F_NEXT;
            end else begin
              state <= F_REQ;
            end
          end
        end
        F_REQ: begin
          if (req.arready) begin
            state <= F_BEATS;
          end
        end
        F_BEATS: begin
          if (line_done) begin
            if (last_line) begin
              state <= F_NEXT;
            end else begin
              line_addr <= line_addr + line_pitch;
              line_idx  <= line_idx + 1'b1;
              state     <= F_REQ;
            end
          end
        end
        default: begin
          state <= F_IDLE;
        end
      endcase
    end
  end

  // one burst per line, its length is the word count less one
  assign req.araddr  = line_addr;
  assign req.arlenw  = LEN_WIDTH'(line_words - 1'b1);
  assign req.arvalid = (state == F_REQ);

  // beats go straight out as pixels, the pixel sink paces the reader
  assign req.rready    = pix_ready;
  assign pix_data      = req.rdata;
  assign pix_valid     = req.rvalid;
  assign pix_line_last = req.rvalid && req.rlast;

  assign frame_done = (state == F_NEXT);

endmodule

// ==== design/fetch_regs.sv ====
`timescale 1ns/1ps

module fetch_regs import fb_pkg::*; #(
  parameter int ADDR_WIDTH = 20,
  parameter int LEN_WIDTH  = 8
) (
  input  logic                  axi_clk,
  input  logic                  axi_resetn,
  input  logic                  reg_wr_en,
  input  reg_addr_e             reg_wr_addr,
  input  logic [ADDR_WIDTH-1:0] reg_wr_data,
  output logic [ADDR_WIDTH-1:0] base_addr,
  output logic [LEN_WIDTH:0]    line_words,
  output logic [ADDR_WIDTH-1:0] line_pitch,
  output logic [ADDR_WIDTH-1:0] line_count,
  output logic                  start
);

  // one write per cycle, every write shows up on the outputs a cycle later
  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      base_addr  <= '0;
      line_words <= '0;
      line_pitch <= '0;
      line_count <= '0;
      start      <= 1'b0;
    end else begin
      // start is a pulse, it falls again unless the start register is hit
      start <= 1'b0;
      if (reg_wr_en) begin
        case (reg_wr_addr)
          REG_BASE:       base_addr  <= reg_wr_data;
          // one more bit than arlenw so a full length line still fits
          REG_LINE_WORDS: line_words <= reg_wr_data[LEN_WIDTH:0];
          REG_PITCH:      line_pitch <= reg_wr_data;
          REG_LINE_COUNT: line_count <= reg_wr_data;
          // the data word of a start write carries nothing
          REG_START:      start      <= 1'b1;
          default: begin
          end
        endcase
      end
    end
  end

endmodule

// ==== design/axi_burst_reader.sv ====
`timescale 1ns/1ps

module axi_burst_reader import axi_pkg::*; #(
  parameter int ADDR_WIDTH = axi_addr_width_def,
  parameter int DATA_WIDTH = axi_data_width_def,
  parameter int LEN_WIDTH  = axi_len_width_def,
  parameter int STRIDE     = axi_stride_def
) (
  input  logic                  axi_clk,
  input  logic                  axi_resetn,
  burst_req_if.reader           req,
  output logic [ADDR_WIDTH-1:0] sub_araddr,
  output logic                  sub_arvalid,
  input  logic                  sub_arready,
  input  logic [DATA_WIDTH-1:0] sub_rdata,
  input  axi_resp_e             sub_rresp,
  input  logic                  sub_rvalid,
  output logic                  sub_rready
);

  // one result entry holds the last flag, the response and the word
  localparam int RES_WIDTH = DATA_WIDTH + 3;

  reader_state_e state;
  reader_state_e next_state;

  logic                  burst_start;
  logic                  beat_read_start;
  logic                  beat_read_accepted;
  logic                  beat_read_done;
  logic                  burst_done;
  logic                  ar_free;
  logic                  issued_last;
  logic [ADDR_WIDTH-1:0] addr;
  logic [ADDR_WIDTH-1:0] addr_max;
  logic                  addr_last;
  logic                  meta_almost_full;
  logic                  meta_last;
  logic                  res_almost_full;
  logic                  res_r_inc;
  logic                  res_r_empty;
  logic [RES_WIDTH-1:0]  res_w_data;
  logic [RES_WIDTH-1:0]  res_r_data;
  logic                  res_valid;

  assign beat_read_accepted = sub_arvalid && sub_arready;
  assign beat_read_done     = sub_rvalid && sub_rready;

  // the address register may be reloaded when it is empty or handed over this cycle
  assign ar_free = !sub_arvalid || sub_arready;

  // a new burst is only taken while nothing else is in flight
  assign req.arready = (state == IDLE);

  always_comb begin
    next_state      = state;
    burst_start     = 1'b0;
    beat_read_start = 1'b0;
    case (state)
      IDLE: begin
        if (req.arvalid) begin
          burst_start = 1'b1;
          next_state  = INIT_BURST;
        end
      end
      INIT_BURST: begin
        // the fifos are drained at this point so the first beat goes out unchecked
        beat_read_start = 1'b1;
        next_state      = READING_BEATS;
      end
      READING_BEATS: begin
        if (!issued_last) begin
          beat_read_start = ar_free && !meta_almost_full && !res_almost_full;
        end else if (ar_free) begin
          next_state = FINISH_BURST;
        end
      end
      FINISH_BURST: begin
        // wait until the controller has taken the beat marked last
        if (burst_done) begin
          next_state = IDLE;
        end
      end
      default: begin
        next_state = IDLE;
      end
    endcase
  end

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      state       <= IDLE;
      issued_last <= 1'b0;
    end else begin
      state <= next_state;
      if (burst_start) begin
        issued_last <= 1'b0;
      end else if (beat_read_start && addr_last) begin
        issued_last <= 1'b1;
      end
    end
  end

  // final beat address of the burst, captured while the request is still on the bus
  always_ff @(posedge axi_clk) begin
    if (burst_start) begin
      addr_max <= req.araddr + ADDR_WIDTH'(STRIDE) *
                  {{(ADDR_WIDTH - LEN_WIDTH){1'b0}}, req.arlenw};
    end
  end

  addr_iter #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .STRIDE     (STRIDE)
  ) i_addr_iter (
    .axi_clk  (axi_clk),
    .init     (burst_start),
    .init_val (req.araddr),
    .max_val  (addr_max),
    .inc      (beat_read_start),
    .val      (addr),
    .last     (addr_last)
  );

  // the address stays put while the subordinate stalls arready
  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      sub_araddr  <= '0;
      sub_arvalid <= 1'b0;
      sub_rready  <= 1'b1;
    end else begin
      sub_rready <= 1'b1;
      if (beat_read_start) begin
        sub_araddr  <= addr;
        sub_arvalid <= 1'b1;
      end else if (beat_read_accepted) begin
        sub_arvalid <= 1'b0;
      end
    end
  end

  // one entry per outstanding address, it remembers which one was the last
  sync_fifo #(
    .DATA_WIDTH      (1),
    .ADDR_SIZE       (3),
    .ALMOST_FULL_BUF (4)
  ) i_meta_fifo (
    .axi_clk       (axi_clk),
    .axi_resetn    (axi_resetn),
    .w_inc         (beat_read_start),
    .w_data        (addr_last),
    .w_almost_full (meta_almost_full),
    .r_inc         (beat_read_done),
    .r_data        (meta_last),
    .r_empty       ()
  );

  // at most four reads are outstanding, and with the buffer of four the result
  // fifo always has room for every beat the subordinate may still return
  assign res_w_data = {meta_last, sub_rresp, sub_rdata};

  sync_fifo #(
    .DATA_WIDTH      (RES_WIDTH),
    .ADDR_SIZE       (3),
    .ALMOST_FULL_BUF (4)
  ) i_res_fifo (
    .axi_clk       (axi_clk),
    .axi_resetn    (axi_resetn),
    .w_inc         (beat_read_done),
    .w_data        (res_w_data),
    .w_almost_full (res_almost_full),
    .r_inc         (res_r_inc),
    .r_data        (res_r_data),
    .r_empty       (res_r_empty)
  );

  assign req.rlast  = res_r_data[RES_WIDTH-1];
  assign req.rresp  = axi_resp_e'(res_r_data[DATA_WIDTH +: 2]);
  assign req.rdata  = res_r_data[DATA_WIDTH-1:0];
  assign req.rvalid = res_valid;

  assign res_r_inc  = !res_r_empty && res_valid && req.rready;
  assign burst_done = res_valid && req.rready && req.rlast;

  // valid drops for one cycle after every transfer, the clear wins over the set
  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      res_valid <= 1'b0;
    end else begin
      if (!res_r_empty) begin
        res_valid <= 1'b1;
      end
      if (res_valid && req.rready) begin
        res_valid <= 1'b0;
      end
    end
  end

endmodule

// ==== design/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
  parameter int DATA_WIDTH      = 8,
  parameter int ADDR_SIZE       = 3,
  parameter int ALMOST_FULL_BUF = 2
) (
  input  logic                  axi_clk,
  input  logic                  axi_resetn,
  input  logic                  w_inc,
  input  logic [DATA_WIDTH-1:0] w_data,
  output logic                  w_almost_full,
  input  logic                  r_inc,
  output logic [DATA_WIDTH-1:0] r_data,
  output logic                  r_empty
);

  localparam int DEPTH = 1 << ADDR_SIZE;

  logic [DATA_WIDTH-1:0] mem [DEPTH];

  // pointers carry one extra bit so full and empty are told apart
  logic [ADDR_SIZE:0] w_ptr;
  logic [ADDR_SIZE:0] r_ptr;
  logic [ADDR_SIZE:0] count;

  assign count   = w_ptr - r_ptr;
  assign r_empty = (count == '0);

  // flag goes up once only the buffer slots or fewer are left
  assign w_almost_full = ((DEPTH - int'(count)) <= ALMOST_FULL_BUF);

  // the head entry is always visible, r_inc only moves on to the next one
  assign r_data = mem[r_ptr[ADDR_SIZE-1:0]];

  always_ff @(posedge axi_clk) begin
    if (w_inc) begin
      mem[w_ptr[ADDR_SIZE-1:0]] <= w_data;
    end
  end

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      w_ptr <= '0;
      r_ptr <= '0;
    end else begin
      if (w_inc) begin
        w_ptr <= w_ptr + 1'b1;
      end
      if (r_inc) begin
        r_ptr <= r_ptr + 1'b1;
      end
    end
  end

endmodule

// ==== design/addr_iter.sv ====
`timescale 1ns/1ps

module addr_iter #(
  parameter int ADDR_WIDTH = 20,
  parameter int STRIDE     = 2
) (
  input  logic                  axi_clk,
  input  logic                  init,
  input  logic [ADDR_WIDTH-1:0] init_val,
  input  logic [ADDR_WIDTH-1:0] max_val,
  input  logic                  inc,
  output logic [ADDR_WIDTH-1:0] val,
  output logic                  last
);

  // the step between two words, sized to the counter
  localparam logic [ADDR_WIDTH-1:0] step = ADDR_WIDTH'(STRIDE);

  // init wins over inc so a new burst always starts from its own address
  always_ff @(posedge axi_clk) begin
    if (init) begin
      val <= init_val;
    end else if (inc) begin
      val <= val + step;
    end
  end

  // last tells the owner that val is already the final address
  // it follows val with no extra cycle
  assign last = (val == max_val);

endmodule

// ==== design/burst_req_if.sv ====
`timescale 1ns/1ps

interface burst_req_if import axi_pkg::*; #(
  parameter int ADDR_WIDTH = axi_addr_width_def,
  parameter int DATA_WIDTH = axi_data_width_def,
  parameter int LEN_WIDTH  = axi_len_width_def
);

  // request channel, arlenw is a zero based word count
  logic [ADDR_WIDTH-1:0] araddr;
  logic [LEN_WIDTH-1:0]  arlenw;
  logic                  arvalid;
  logic                  arready;

  // returned beats, the beat with rlast closes the burst
  logic [DATA_WIDTH-1:0] rdata;
  axi_resp_e             rresp;
  logic                  rvalid;
  logic                  rready;
  logic                  rlast;

  // the controller asks for lines and takes the words
  modport ctrl (
    output araddr, arlenw, arvalid, rready,
    input  arready, rdata, rresp, rvalid, rlast
  );

  // the reader serves one burst at a time
  modport reader (
    input  araddr, arlenw, arvalid, rready,
    output arready, rdata, rresp, rvalid, rlast
  );

endinterface

// ==== design/fb_pkg.sv ====
package fb_pkg;

  // five registers do not fit into two address bits, so the map is three bits wide
  localparam int reg_addr_width = 3;

  // register map of the fetch register block
  typedef enum logic [reg_addr_width-1:0] {
    REG_BASE       = 3'd0,
    REG_LINE_WORDS = 3'd1,
    REG_PITCH      = 3'd2,
    REG_LINE_COUNT = 3'd3,
    REG_START      = 3'd4
  } reg_addr_e;

  // line fetch controller FSM
  // f_next is the single wrap-up cycle after the final line of a frame
  typedef enum logic [1:0] {
    F_IDLE  = 2'b00,
    F_REQ   = 2'b01,
    F_BEATS = 2'b10,
    F_NEXT  = 2'b11
  } fetch_state_e;

endpackage

// ==== design/axi_pkg.sv ====
package axi_pkg;

  // default bus geometry, the top level hands these down as module parameters
  localparam int axi_addr_width_def = 20;
  localparam int axi_data_width_def = 16;
  localparam int axi_len_width_def  = 8;

  // byte distance between two consecutive words of the frame buffer
  localparam int axi_stride_def = 2;

  // read response code as it comes back from the subordinate
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  // burst reader FSM
  // init_burst loads the address iterator before the first beat goes out
  typedef enum logic [1:0] {
    IDLE          = 2'b00,
    INIT_BURST    = 2'b01,
    READING_BEATS = 2'b10,
    FINISH_BURST  = 2'b11
  } reader_state_e;

endpackage
